/* compile.f */
logic/exePkg.sv
logic/exeBundleIf.sv
logic/aluBranchUnit.sv
logic/mulDivUnit.sv
logic/dataMem.sv
logic/writebackSelect.sv
logic/exeStage.sv
testbench/exeStage_sva.sv
testbench/exeStageTb.sv

/* logic/aluBranchUnit.sv */
`timescale 1ns/1ps

module aluBranchUnit (
	exeBundleIf.unit bundle,
	output exePkg::word_t aluResult,
	output logic redirect,
	output exePkg::word_t target
);

	logic [4:0] shamt;
	logic isEqual;
	logic signedLt;
	logic unsignedLt;
	logic brCond;
	exePkg::word_t jumpBase;
	exePkg::word_t jumpSum;

	assign shamt = bundle.opB[4:0]; // only low five bits count
	assign isEqual = (bundle.opA == bundle.opB);
	assign signedLt = ($signed(bundle.opA) < $signed(bundle.opB));
	assign unsignedLt = (bundle.opA < bundle.opB);

	always_comb
	begin
		case (bundle.aluOp)
			exePkg::ALU_ADD:
				aluResult = bundle.opA + bundle.opB;
			exePkg::ALU_SUB:
				aluResult = bundle.opA - bundle.opB;
			exePkg::ALU_SLL:
				aluResult = bundle.opA << shamt;
			exePkg::ALU_SLT:
				aluResult = {31'b0, signedLt};
			exePkg::ALU_SLTU:
				aluResult = {31'b0, unsignedLt};
			exePkg::ALU_XOR:
				aluResult = bundle.opA ^ bundle.opB;
			exePkg::ALU_SRL:
				aluResult = bundle.opA >> shamt;
			exePkg::ALU_SRA:
				aluResult = $signed(bundle.opA) >>> shamt; // sign fill
			exePkg::ALU_OR:
				aluResult = bundle.opA | bundle.opB;
			exePkg::ALU_AND:
				aluResult = bundle.opA & bundle.opB;
			default:
				aluResult = '0;
		endcase
	end

	// branch condition from funct3
	always_comb
	begin
		case (bundle.brOp)
			exePkg::BR_EQ:
				brCond = isEqual;
			exePkg::BR_NE:
				brCond = !isEqual;
			exePkg::BR_LT:
				brCond = signedLt;
			exePkg::BR_GE:
				brCond = !signedLt;
			exePkg::BR_LTU:
				brCond = unsignedLt;
			exePkg::BR_GEU:
				brCond = !unsignedLt;
			default:
				brCond = 1'b0; // funct3 2 and 3 are reserved
		endcase
	end

	assign redirect = bundle.valid &
		(bundle.isJal | bundle.isJalr | (bundle.isBranch & brCond));

	// jalr is register relative, everything else pc relative
	assign jumpBase = bundle.isJalr ? bundle.opA : bundle.pc;
	assign jumpSum = jumpBase + bundle.imm;
	assign target = bundle.isJalr ? {jumpSum[31:1], 1'b0} : jumpSum;

endmodule

/* logic/dataMem.sv */
`timescale 1ns/1ps

// memWords is expected to be a power of two
module dataMem #(
	parameter int memWords = 256
) (
	input logic clk,
	input logic nrst,
	exeBundleIf.unit bundle,
	output exePkg::word_t loadData,
	output logic addrMisaligned
);

	localparam int idxBits = $clog2(memWords);

	exePkg::word_t ram [memWords];
	exePkg::word_t addr;
	logic [idxBits-1:0] wordIdx;
	logic [1:0] lane;
	logic isLoad;
	logic isStore;
	logic isHalf;
	logic isWord;
	logic misaligned;
	logic storeEn;
	logic [3:0] byteEn;
	exePkg::word_t storeData;
	exePkg::word_t readWord;
	exePkg::memOp_t memOpQ;
	logic [1:0] laneQ;
	logic [7:0] loadByte;
	logic [15:0] loadHalf;

	assign addr = bundle.opA + bundle.imm;
	assign lane = addr[1:0];
	assign wordIdx = addr[idxBits+1:2]; // wraps around the RAM size

	always_comb
	begin
		isLoad = (bundle.memOp == exePkg::MEM_LB) || (bundle.memOp == exePkg::MEM_LBU) ||
			(bundle.memOp == exePkg::MEM_LH) || (bundle.memOp == exePkg::MEM_LHU) ||
			(bundle.memOp == exePkg::MEM_LW);
		isStore = (bundle.memOp == exePkg::MEM_SB) || (bundle.memOp == exePkg::MEM_SH) ||
			(bundle.memOp == exePkg::MEM_SW);
		isHalf = (bundle.memOp == exePkg::MEM_LH) || (bundle.memOp == exePkg::MEM_LHU) ||
			(bundle.memOp == exePkg::MEM_SH);
		isWord = (bundle.memOp == exePkg::MEM_LW) || (bundle.memOp == exePkg::MEM_SW);
	end

	assign misaligned = (isHalf & addr[0]) | (isWord & (addr[1:0] != 2'b00));
	assign storeEn = bundle.valid & isStore & !misaligned;

	// byte lanes and replicated store data
	always_comb
	begin
		if (bundle.memOp == exePkg::MEM_SW)
		begin
			byteEn = 4'b1111;
			storeData = bundle.opB;
		end
		else if (bundle.memOp == exePkg::MEM_SH)
		begin
			byteEn = 4'b0011 << lane;
			storeData = {2{bundle.opB[15:0]}};
		end
		else
		begin
			byteEn = 4'b0001 << lane;
			storeData = {4{bundle.opB[7:0]}};
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (storeEn && byteEn[i])
				ram[wordIdx][i*8 +: 8] <= storeData[i*8 +: 8];
		end
	end

	// read side lines up with stage 6
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			readWord <= '0;
			memOpQ <= exePkg::MEM_NONE;
			laneQ <= 2'b00;
			addrMisaligned <= 1'b0;
		end
		else
		begin
			readWord <= ram[wordIdx]; // old data on a same-edge store
			memOpQ <= bundle.memOp;
			laneQ <= lane;
			addrMisaligned <= bundle.valid & (isLoad | isStore) & misaligned;
		end
	end

	assign loadByte = readWord[{laneQ, 3'b000} +: 8];
	assign loadHalf = readWord[{laneQ[1], 4'b0000} +: 16];

	always_comb
	begin
		case (memOpQ)
			exePkg::MEM_LB:
				loadData = {{24{loadByte[7]}}, loadByte};
			exePkg::MEM_LBU:
				loadData = {24'b0, loadByte};
			exePkg::MEM_LH:
				loadData = {{16{loadHalf[15]}}, loadHalf};
			exePkg::MEM_LHU:
				loadData = {16'b0, loadHalf};
			exePkg::MEM_LW:
				loadData = readWord;
			default:
				loadData = '0;
		endcase
	end

endmodule

/* logic/exeBundleIf.sv */
`timescale 1ns/1ps

// registered stage 5 contents shared by the execute units
interface exeBundleIf;
	logic valid;
	exePkg::word_t opA;
	exePkg::word_t opB;
	exePkg::word_t imm;
	exePkg::word_t pc;
	exePkg::aluOp_t aluOp;
	exePkg::brOp_t brOp;
	logic isBranch;
	logic isJal;
	logic isJalr;
	exePkg::mulDivOp_t mulDivOp;
	exePkg::memOp_t memOp;

	modport stage (
		output valid, opA, opB, imm, pc, aluOp, brOp,
		output isBranch, isJal, isJalr, mulDivOp, memOp
	);

	modport unit (
		input valid, opA, opB, imm, pc, aluOp, brOp,
		input isBranch, isJal, isJalr, mulDivOp, memOp
	);
endinterface

/* logic/exePkg.sv */
package exePkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [3:0] aluOp_t;
	typedef logic [2:0] brOp_t;     // branch funct3
	typedef logic [2:0] mulDivOp_t; // RV32M funct3
	typedef logic [3:0] memOp_t;
	typedef logic [2:0] wbSel_t;

	localparam aluOp_t ALU_ADD  = 4'd0;
	localparam aluOp_t ALU_SUB  = 4'd1;
	localparam aluOp_t ALU_SLL  = 4'd2;
	localparam aluOp_t ALU_SLT  = 4'd3;
	localparam aluOp_t ALU_SLTU = 4'd4;
	localparam aluOp_t ALU_XOR  = 4'd5;
	localparam aluOp_t ALU_SRL  = 4'd6;
	localparam aluOp_t ALU_SRA  = 4'd7;
	localparam aluOp_t ALU_OR   = 4'd8;
	localparam aluOp_t ALU_AND  = 4'd9;

	// same values as the branch funct3 field
	localparam brOp_t BR_EQ  = 3'd0;
	localparam brOp_t BR_NE  = 3'd1;
	localparam brOp_t BR_LT  = 3'd4;
	localparam brOp_t BR_GE  = 3'd5;
	localparam brOp_t BR_LTU = 3'd6;
	localparam brOp_t BR_GEU = 3'd7;

	localparam mulDivOp_t MD_MUL    = 3'd0;
	localparam mulDivOp_t MD_MULH   = 3'd1;
	localparam mulDivOp_t MD_MULHSU = 3'd2;
	localparam mulDivOp_t MD_MULHU  = 3'd3;
	localparam mulDivOp_t MD_DIV    = 3'd4;
	localparam mulDivOp_t MD_DIVU   = 3'd5;
	localparam mulDivOp_t MD_REM    = 3'd6;
	localparam mulDivOp_t MD_REMU   = 3'd7;

	localparam memOp_t MEM_NONE = 4'd0;
	localparam memOp_t MEM_LB   = 4'd1;
	localparam memOp_t MEM_LH   = 4'd2;
	localparam memOp_t MEM_LW   = 4'd3;
	localparam memOp_t MEM_LBU  = 4'd4;
	localparam memOp_t MEM_LHU  = 4'd5;
	localparam memOp_t MEM_SB   = 4'd6;
	localparam memOp_t MEM_SH   = 4'd7;
	localparam memOp_t MEM_SW   = 4'd8;

	localparam wbSel_t WB_ALU    = 3'd0;
	localparam wbSel_t WB_LINK   = 3'd1; // pc+4
	localparam wbSel_t WB_MULDIV = 3'd2;
	localparam wbSel_t WB_UIMM   = 3'd3; // lui
	localparam wbSel_t WB_LOAD   = 3'd4;
	localparam wbSel_t WB_AUIPC  = 3'd5;

endpackage

/* logic/exeStage.sv */
`timescale 1ns/1ps

module exeStage #(
	parameter int memWords = 256
) (
	input logic clk,
	input logic nrst,
	input logic issueValid,
	input exePkg::word_t opA,
	input exePkg::word_t opB,
	input exePkg::word_t imm,
	input exePkg::word_t pc,
	input exePkg::regAddr_t rd,
	input exePkg::aluOp_t aluOp,
	input exePkg::brOp_t brOp,
	input logic isBranch,
	input logic isJal,
	input logic isJalr,
	input exePkg::mulDivOp_t mulDivOp,
	input exePkg::memOp_t memOp,
	input exePkg::wbSel_t wbSel,
	input logic we,
	output exePkg::word_t wbData,
	output logic wbWe,
	output exePkg::regAddr_t wbRd,
	output logic addrMisaligned,
	output logic redirect,
	output exePkg::word_t target
);

	exeBundleIf bundle ();

	exePkg::regAddr_t rdQ;
	logic weQ;
	exePkg::wbSel_t wbSelQ;
	exePkg::word_t aluResult;
	exePkg::word_t mulDivResult;
	exePkg::word_t loadData;

	// stage 5 register, a new instruction may land every cycle
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			bundle.valid <= 1'b0;
			bundle.opA <= '0;
			bundle.opB <= '0;
			bundle.imm <= '0;
			bundle.pc <= '0;
			bundle.aluOp <= exePkg::ALU_ADD;
			bundle.brOp <= exePkg::BR_EQ;
			bundle.isBranch <= 1'b0;
			bundle.isJal <= 1'b0;
			bundle.isJalr <= 1'b0;
			bundle.mulDivOp <= exePkg::MD_MUL;
			bundle.memOp <= exePkg::MEM_NONE;
			rdQ <= '0;
			weQ <= 1'b0;
			wbSelQ <= exePkg::WB_ALU;
		end
		else
		begin
			bundle.valid <= issueValid;
			bundle.opA <= opA;
			bundle.opB <= opB;
			bundle.imm <= imm;
			bundle.pc <= pc;
			bundle.aluOp <= aluOp;
			bundle.brOp <= brOp;
			bundle.isBranch <= isBranch;
			bundle.isJal <= isJal;
			bundle.isJalr <= isJalr;
			bundle.mulDivOp <= mulDivOp;
			bundle.memOp <= memOp;
			rdQ <= rd;
			weQ <= we;
			wbSelQ <= wbSel;
		end
	end

	aluBranchUnit aluBranch_i (
		.bundle   (bundle.unit),
		.aluResult(aluResult),
		.redirect (redirect),
		.target   (target)
	);

	mulDivUnit mulDiv_i (
		.bundle      (bundle.unit),
		.mulDivResult(mulDivResult)
	);

	dataMem #(
		.memWords(memWords)
	) dataMem_i (
		.clk           (clk),
		.nrst          (nrst),
		.bundle        (bundle.unit),
		.loadData      (loadData),
		.addrMisaligned(addrMisaligned)
	);

	writebackSelect wbSelect_i (
		.clk         (clk),
		.nrst        (nrst),
		.valid       (bundle.valid),
		.we          (weQ),
		.rd          (rdQ),
		.wbSel       (wbSelQ),
		.pc          (bundle.pc),
		.imm         (bundle.imm),
		.aluResult   (aluResult),
		.mulDivResult(mulDivResult),
		.loadData    (loadData),
		.wbData      (wbData),
		.wbWe        (wbWe),
		.wbRd        (wbRd)
	);

endmodule

/* logic/mulDivUnit.sv */
`timescale 1ns/1ps

module mulDivUnit (
	exeBundleIf.unit bundle,
	output exePkg::word_t mulDivResult
);

	logic aSigned;
	logic bSigned;
	logic signed [32:0] mulA;
	logic signed [32:0] mulB;
	logic signed [65:0] fullProduct;
	logic [63:0] product;
	logic signedDiv;
	logic divByZero;
	logic divOverflow;
	exePkg::word_t absA;
	exePkg::word_t absB;
	exePkg::word_t magQuot;
	exePkg::word_t magRem;
	exePkg::word_t quotient;
	exePkg::word_t remainder;

	// mulh treats both signed, mulhsu only A, mulhu neither
	assign aSigned = (bundle.mulDivOp == exePkg::MD_MULH) ||
		(bundle.mulDivOp == exePkg::MD_MULHSU);
	assign bSigned = (bundle.mulDivOp == exePkg::MD_MULH);

	assign mulA = {aSigned & bundle.opA[31], bundle.opA};
	assign mulB = {bSigned & bundle.opB[31], bundle.opB};
	assign fullProduct = mulA * mulB;
	assign product = fullProduct[63:0];

	assign signedDiv = (bundle.mulDivOp == exePkg::MD_DIV) ||
		(bundle.mulDivOp == exePkg::MD_REM);
	assign divByZero = (bundle.opB == '0);
	assign divOverflow = signedDiv && (bundle.opA == 32'h8000_0000) &&
		(bundle.opB == 32'hffff_ffff);

	// one unsigned divider on magnitudes serves all four ops
	assign absA = (signedDiv && bundle.opA[31]) ? -bundle.opA : bundle.opA;
	assign absB = (signedDiv && bundle.opB[31]) ? -bundle.opB : bundle.opB;
	assign magQuot = absA / absB;
	assign magRem = absA % absB;

	assign quotient = (signedDiv && (bundle.opA[31] ^ bundle.opB[31])) ? -magQuot : magQuot;
	assign remainder = (signedDiv && bundle.opA[31]) ? -magRem : magRem; // follows dividend

	always_comb
	begin
		case (bundle.mulDivOp)
			exePkg::MD_MUL:
				mulDivResult = product[31:0];
			exePkg::MD_MULH, exePkg::MD_MULHSU, exePkg::MD_MULHU:
				mulDivResult = product[63:32];
			exePkg::MD_DIV, exePkg::MD_DIVU:
			begin
				if (divByZero)
					mulDivResult = '1;
				else if (divOverflow)
					mulDivResult = bundle.opA;
				else
					mulDivResult = quotient;
			end
			exePkg::MD_REM, exePkg::MD_REMU:
			begin
				if (divByZero)
					mulDivResult = bundle.opA;
				else if (divOverflow)
					mulDivResult = '0;
				else
					mulDivResult = remainder;
			end
			default:
				mulDivResult = '0;
		endcase
	end

endmodule

/* logic/writebackSelect.sv */
`timescale 1ns/1ps

module writebackSelect (
	input logic clk,
	input logic nrst,
	input logic valid,
	input logic we,
	input exePkg::regAddr_t rd,
	input exePkg::wbSel_t wbSel,
	input exePkg::word_t pc,
	input exePkg::word_t imm,
	input exePkg::word_t aluResult,
	input exePkg::word_t mulDivResult,
	input exePkg::word_t loadData,
	output exePkg::word_t wbData,
	output logic wbWe,
	output exePkg::regAddr_t wbRd
);

	exePkg::wbSel_t wbSelQ;
	exePkg::word_t aluQ;
	exePkg::word_t linkQ;
	exePkg::word_t mulDivQ;
	exePkg::word_t uimmQ;
	exePkg::word_t auipcQ;

	// stage 6 register
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			wbWe <= 1'b0;
			wbRd <= '0;
			wbSelQ <= exePkg::WB_ALU;
			aluQ <= '0;
			linkQ <= '0;
			mulDivQ <= '0;
			uimmQ <= '0;
			auipcQ <= '0;
		end
		else
		begin
			wbWe <= valid & we; // bubbles never write
			wbRd <= rd;
			wbSelQ <= wbSel;
			aluQ <= aluResult;
			linkQ <= pc + 32'd4;
			mulDivQ <= mulDivResult;
			uimmQ <= imm;
			auipcQ <= pc + imm;
		end
	end

	always_comb
	begin
		case (wbSelQ)
			exePkg::WB_ALU:    wbData = aluQ;
			exePkg::WB_LINK:   wbData = linkQ;
			exePkg::WB_MULDIV: wbData = mulDivQ;
			exePkg::WB_UIMM:   wbData = uimmQ;
			exePkg::WB_LOAD:   wbData = loadData; // already registered in dataMem
			exePkg::WB_AUIPC:  wbData = auipcQ;
			default:           wbData = '0;
		endcase
	end

endmodule

/* run.sh */
#!/bin/sh
# build the execute stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timing -f compile.f --top-module exeStageTb \
	-Mdir obj_dir -o exeStageSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/exeStageSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
	echo "no result line found in $LOG"
	exit 1
fi
exit 0

/* testbench/exeStageTb.sv */
`timescale 1ns/1ps

module exeStageTb;

	localparam int memWords = 256;
	localparam int cycleLimit = 400; // about twice the test length
	localparam exePkg::word_t memBase = 32'h0000_0200;

	logic clk;
	logic nrst;
	logic issueValid;
	exePkg::word_t opA;
	exePkg::word_t opB;
	exePkg::word_t imm;
	exePkg::word_t pc;
	exePkg::regAddr_t rd;
	exePkg::aluOp_t aluOp;
	exePkg::brOp_t brOp;
	logic isBranch;
	logic isJal;
	logic isJalr;
	exePkg::mulDivOp_t mulDivOp;
	exePkg::memOp_t memOp;
	exePkg::wbSel_t wbSel;
	logic we;
	exePkg::word_t wbData;
	logic wbWe;
	exePkg::regAddr_t wbRd;
	logic addrMisaligned;
	logic redirect;
	exePkg::word_t target;

	int errors;
	int cycles;
	exePkg::word_t lcgState = 32'd19;

	exeStage #(
		.memWords(memWords)
	) dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function exePkg::word_t nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic exePkg::word_t aluRef(input exePkg::aluOp_t op,
		input exePkg::word_t a, input exePkg::word_t b);
		case (op)
			exePkg::ALU_ADD:  return a + b;
			exePkg::ALU_SUB:  return a - b;
			exePkg::ALU_SLL:  return a << b[4:0];
			exePkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
			exePkg::ALU_SLTU: return {31'b0, a < b};
			exePkg::ALU_XOR:  return a ^ b;
			exePkg::ALU_SRL:  return a >> b[4:0];
			exePkg::ALU_SRA:  return $signed(a) >>> b[4:0];
			exePkg::ALU_OR:   return a | b;
			default:          return a & b;
		endcase
	endfunction

	function automatic logic brRef(input exePkg::brOp_t op,
		input exePkg::word_t a, input exePkg::word_t b);
		case (op)
			exePkg::BR_EQ:  return a == b;
			exePkg::BR_NE:  return a != b;
			exePkg::BR_LT:  return $signed(a) < $signed(b);
			exePkg::BR_GE:  return $signed(a) >= $signed(b);
			exePkg::BR_LTU: return a < b;
			exePkg::BR_GEU: return a >= b;
			default:        return 1'b0;
		endcase
	endfunction

	function automatic exePkg::word_t mulDivRef(input exePkg::mulDivOp_t op,
		input exePkg::word_t a, input exePkg::word_t b);
		longint sa;
		longint sb;
		longint ua;
		longint ub;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		ua = {32'b0, a};
		ub = {32'b0, b};
		case (op)
			exePkg::MD_MUL:    return exePkg::word_t'(sa * sb);
			exePkg::MD_MULH:   return exePkg::word_t'((sa * sb) >> 32);
			exePkg::MD_MULHSU: return exePkg::word_t'((sa * ub) >> 32);
			exePkg::MD_MULHU:  return exePkg::word_t'((ua * ub) >> 32);
			default: ;
		endcase
		if (b == '0) // quotient all ones, remainder is the dividend
			return (op == exePkg::MD_DIV || op == exePkg::MD_DIVU) ? '1 : a;
		// 64-bit math, so min / -1 gives min and its remainder 0
		case (op)
			exePkg::MD_DIV:  return exePkg::word_t'(sa / sb);
			exePkg::MD_DIVU: return exePkg::word_t'(ua / ub);
			exePkg::MD_REM:  return exePkg::word_t'(sa % sb);
			default:         return exePkg::word_t'(ua % ub);
		endcase
	endfunction

	task automatic setDefaults();
		opA = '0;
		opB = '0;
		imm = '0;
		pc = '0;
		rd = '0;
		aluOp = exePkg::ALU_ADD;
		brOp = exePkg::BR_EQ;
		isBranch = 1'b0;
		isJal = 1'b0;
		isJalr = 1'b0;
		mulDivOp = exePkg::MD_MUL;
		memOp = exePkg::MEM_NONE;
		wbSel = exePkg::WB_ALU;
		we = 1'b1;
	endtask

	task automatic checkRedirect(input logic expRedirect, input exePkg::word_t expTarget);
		assert (redirect === expRedirect && (!expRedirect || target === expTarget))
		else
		begin
			errors++;
			$display("ERROR at %0t: redirect %b target %h, expected %b %h",
				$time, redirect, target, expRedirect, expTarget);
		end
	endtask

	task automatic checkWriteback(input logic expWe, input exePkg::regAddr_t expRd,
		input exePkg::word_t expData, input logic expMisaligned);
		assert (wbWe === expWe && addrMisaligned === expMisaligned &&
			(!expWe || (wbRd === expRd && wbData === expData)))
		else
		begin
			errors++;
			$display("ERROR at %0t: we %b rd %0d data %h mis %b, expected %b %0d %h %b",
				$time, wbWe, wbRd, wbData, addrMisaligned,
				expWe, expRd, expData, expMisaligned);
		end
	endtask

	// called just after a falling edge, returns on the falling edge of the write-back cycle
	task automatic issueAndCheck(input logic valid, input logic expRedirect,
		input exePkg::word_t expTarget, input exePkg::word_t expData,
		input logic expMisaligned);
		exePkg::regAddr_t issuedRd;
		logic issuedWe;
		issuedRd = rd;
		issuedWe = we;
		issueValid = valid;
		@(negedge clk);
		issueValid = 1'b0;
		checkRedirect(valid & expRedirect, expTarget);
		@(negedge clk);
		checkWriteback(valid & issuedWe, issuedRd, expData, valid & expMisaligned);
	endtask

	task automatic testAlu();
		exePkg::aluOp_t aluOps[10] = '{exePkg::ALU_ADD, exePkg::ALU_SUB, exePkg::ALU_SLL,
			exePkg::ALU_SLT, exePkg::ALU_SLTU, exePkg::ALU_XOR, exePkg::ALU_SRL,
			exePkg::ALU_SRA, exePkg::ALU_OR, exePkg::ALU_AND};
		for (int i = 0; i < 10; i++)
		begin
			for (int j = 0; j < 4; j++)
			begin
				setDefaults();
				aluOp = aluOps[i];
				rd = exePkg::regAddr_t'(i * 3 + j + 1);
				opA = nextRandom();
				opB = nextRandom();
				if (j == 1)
				begin
					opA = 32'h8000_0000;
					opB = 32'h0000_0021; // shift amount 33
				end
				else if (j == 2)
				begin
					opA = 32'h7fff_ffff;
					opB = 32'hffff_ffff;
				end
				else if (j == 3)
					opB = 32'h0000_003f;
				issueAndCheck(1'b1, 1'b0, '0, aluRef(aluOps[i], opA, opB), 1'b0);
			end
		end
	endtask

	task automatic testBranch();
		exePkg::brOp_t brOps[6] = '{exePkg::BR_EQ, exePkg::BR_NE, exePkg::BR_LT,
			exePkg::BR_GE, exePkg::BR_LTU, exePkg::BR_GEU};
		exePkg::word_t brA[3] = '{32'd5, 32'hffff_ffff, 32'd1};
		exePkg::word_t brB[3] = '{32'd5, 32'd1, 32'hffff_ffff};
		for (int i = 0; i < 6; i++)
		begin
			for (int j = 0; j < 3; j++)
			begin
				setDefaults();
				isBranch = 1'b1;
				we = 1'b0;
				brOp = brOps[i];
				opA = brA[j];
				opB = brB[j];
				pc = nextRandom() & 32'hffff_fffc;
				imm = nextRandom() & 32'h0000_1ffe;
				issueAndCheck(1'b1, brRef(brOps[i], brA[j], brB[j]), pc + imm, '0, 1'b0);
			end
		end
		setDefaults();
		isJal = 1'b1;
		wbSel = exePkg::WB_LINK;
		rd = 5'd1;
		pc = 32'h0000_2000;
		imm = 32'hffff_fff0;
		issueAndCheck(1'b1, 1'b1, 32'h0000_1ff0, 32'h0000_2004, 1'b0);
		setDefaults();
		isJalr = 1'b1;
		wbSel = exePkg::WB_LINK;
		rd = 5'd1;
		pc = 32'h0000_3000;
		opA = 32'h0000_1001;
		imm = 32'h0000_0010;
		issueAndCheck(1'b1, 1'b1, 32'h0000_1010, 32'h0000_3004, 1'b0); // bit 0 dropped
	endtask

	task automatic testMulDiv();
		exePkg::mulDivOp_t mdOps[8] = '{exePkg::MD_MUL, exePkg::MD_MULH, exePkg::MD_MULHSU,
			exePkg::MD_MULHU, exePkg::MD_DIV, exePkg::MD_DIVU, exePkg::MD_REM, exePkg::MD_REMU};
		for (int i = 0; i < 8; i++)
		begin
			for (int j = 0; j < 3; j++)
			begin
				setDefaults();
				mulDivOp = mdOps[i];
				wbSel = exePkg::WB_MULDIV;
				rd = exePkg::regAddr_t'(i * 3 + j + 2);
				opA = (j == 2) ? 32'h8000_0000 : nextRandom();
				opB = (j == 2) ? 32'hffff_ffff : nextRandom();
				if (j == 1)
					opB = '0;
				issueAndCheck(1'b1, 1'b0, '0, mulDivRef(mdOps[i], opA, opB), 1'b0);
			end
		end
	endtask

	task automatic memAccess(input exePkg::memOp_t op, input exePkg::word_t offset,
		input exePkg::word_t storeVal, input exePkg::word_t expLoad, input logic expMisaligned);
		setDefaults();
		memOp = op;
		opA = memBase;
		imm = offset;
		opB = storeVal;
		rd = 5'd9;
		wbSel = exePkg::WB_LOAD;
		we = !(op == exePkg::MEM_SB || op == exePkg::MEM_SH || op == exePkg::MEM_SW);
		issueAndCheck(1'b1, 1'b0, '0, expLoad, expMisaligned);
	endtask

	task automatic testMemory();
		memAccess(exePkg::MEM_SW, 32'd0, 32'h8765_4321, '0, 1'b0);
		memAccess(exePkg::MEM_LW, 32'd0, '0, 32'h8765_4321, 1'b0);
		memAccess(exePkg::MEM_SH, 32'd2, 32'h1234_f0a5, '0, 1'b0); // word now f0a54321
		memAccess(exePkg::MEM_LH, 32'd2, '0, 32'hffff_f0a5, 1'b0);
		memAccess(exePkg::MEM_LHU, 32'd2, '0, 32'h0000_f0a5, 1'b0);
		memAccess(exePkg::MEM_SB, 32'd1, 32'hcafe_0080, '0, 1'b0); // word now f0a58021
		memAccess(exePkg::MEM_LB, 32'd1, '0, 32'hffff_ff80, 1'b0);
		memAccess(exePkg::MEM_LBU, 32'd1, '0, 32'h0000_0080, 1'b0);
		memAccess(exePkg::MEM_LB, 32'd0, '0, 32'h0000_0021, 1'b0);
		memAccess(exePkg::MEM_LW, 32'd0, '0, 32'hf0a5_8021, 1'b0);
		memAccess(exePkg::MEM_SW, 32'd1, 32'hdead_beef, '0, 1'b1);
		memAccess(exePkg::MEM_LW, 32'd0, '0, 32'hf0a5_8021, 1'b0); // misaligned store dropped
	endtask

	task automatic testWbSources();
		setDefaults();
		wbSel = exePkg::WB_UIMM;
		rd = 5'd10;
		imm = 32'habcd_e000;
		issueAndCheck(1'b1, 1'b0, '0, 32'habcd_e000, 1'b0);
		setDefaults();
		wbSel = exePkg::WB_AUIPC;
		rd = 5'd11;
		pc = 32'h0000_0400;
		imm = 32'h1234_5000;
		issueAndCheck(1'b1, 1'b0, '0, 32'h1234_5400, 1'b0);
	endtask

	task automatic testBubbles();
		setDefaults();
		isJal = 1'b1; // would redirect if it were valid
		rd = 5'd12;
		issueAndCheck(1'b0, 1'b1, '0, '0, 1'b0);
	endtask

	task automatic testPipeline();
		exePkg::word_t firstA;
		exePkg::word_t firstB;
		exePkg::word_t secondA;
		exePkg::word_t secondB;
		firstA = nextRandom();
		firstB = nextRandom();
		secondA = nextRandom();
		secondB = nextRandom();
		setDefaults();
		opA = firstA;
		opB = firstB;
		rd = 5'd7;
		issueValid = 1'b1;
		@(negedge clk);
		opA = secondA; // second instruction right behind the first
		opB = secondB;
		mulDivOp = exePkg::MD_MUL;
		wbSel = exePkg::WB_MULDIV;
		rd = 5'd8;
		checkRedirect(1'b0, '0);
		@(negedge clk);
		issueValid = 1'b0;
		checkRedirect(1'b0, '0);
		checkWriteback(1'b1, 5'd7, firstA + firstB, 1'b0);
		@(negedge clk);
		checkWriteback(1'b1, 5'd8, mulDivRef(exePkg::MD_MUL, secondA, secondB), 1'b0);
	endtask

	initial
	begin
		cycles = 0;
		while (cycles < cycleLimit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", cycleLimit);
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		errors = 0;
		nrst = 1'b0;
		issueValid = 1'b0;
		setDefaults();
		repeat (2) @(negedge clk);
		nrst = 1'b1;
		testAlu();
		testBranch();
		testMulDiv();
		testMemory();
		testWbSources();
		testBubbles();
		testPipeline();
		$display("tests done, errors: %0d", errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* testbench/exeStage_sva.sv */
`timescale 1ns/1ps

module exeStageSva (
	input logic clk,
	input logic nrst,
	input logic issueValid,
	input logic we,
	input logic wbWe,
	input logic redirect
);

	// outputs stay quiet in reset
	property quietInReset;
		@(posedge clk) !nrst |-> (!wbWe && !redirect);
	endproperty

	property noRedirectOnBubble;
		@(posedge clk) disable iff (!nrst) !issueValid |=> !redirect;
	endproperty

	// two edges from sample to write-back
	property wbWeLatency;
		@(posedge clk) disable iff (!nrst) wbWe == $past(issueValid && we, 2);
	endproperty

	assert property (quietInReset)
	else $error("wbWe or redirect high during reset");

	assert property (noRedirectOnBubble)
	else $error("redirect raised after a bubble");

	assert property (wbWeLatency)
	else $error("wbWe does not follow issueValid and we by two edges");

endmodule

bind exeStage exeStageSva sva_i (
	.clk       (clk),
	.nrst      (nrst),
	.issueValid(issueValid),
	.we        (we),
	.wbWe      (wbWe),
	.redirect  (redirect)
);
